//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes from bits [6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011
  } opcode_t;

  // Bit positions of the register and funct3 fields
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;

  typedef logic [2:0] funct3_t;

  // Same encoding as funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SRL  = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_cmd_t;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cmd_t;

endpackage

`default_nettype wire

//--- logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;

  // Data word of the integer datapath
  typedef logic [XLEN-1:0] word_t;

  // Word address, byte address without the two low bits
  typedef logic [XLEN-3:0] pc_t;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
  parameter pc_t BOOT_PC = '0
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  input  wire logic  redir_valid_i,
  input  wire pc_t   redir_pc_i,
  input  wire logic  ready_i,
  output logic       valid_o,
  output word_t      instr_o,
  output pc_t        pc_o,
  output logic       ibus_cyc_o,
  output logic       ibus_stb_o,
  output pc_t        ibus_addr_o,
  input  wire logic  ibus_stall_i,
  input  wire logic  ibus_ack_i,
  input  wire word_t ibus_data_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} fetch_state_t;

  fetch_state_t state_q;
  fetch_state_t state_d;
  pc_t pc_q;
  pc_t pc_d;
  logic discard_q;
  logic drop_ack;

  assign valid_o    = (state_q == HOLD);
  assign ibus_stb_o = (state_q == REQ);
  assign ibus_cyc_o = (state_q == REQ) || (state_q == WAIT);

  // Ack of a fetch that a redirect has overtaken
  assign drop_ack = discard_q || redir_valid_i;

  assign pc_d = redir_valid_i ? redir_pc_i :
                (valid_o && ready_i) ? pc_q + 1'b1 : pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: state_d = REQ;
      REQ: begin
        if (!ibus_stall_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (ibus_ack_i) begin
          state_d = drop_ack ? REQ : HOLD;
        end
      end
      HOLD: begin
        if (redir_valid_i || ready_i) begin
          state_d = REQ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      pc_q        <= BOOT_PC;
      discard_q   <= 1'b0;
      ibus_addr_o <= BOOT_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (state_q == WAIT && ibus_ack_i) begin
        discard_q <= 1'b0;
      end else if (ibus_cyc_o && redir_valid_i) begin
        discard_q <= 1'b1;
      end
      // Latched as a request opens, held until accepted
      if (state_d == REQ && state_q != REQ) begin
        ibus_addr_o <= pc_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WAIT && ibus_ack_i) begin
      instr_o <= ibus_data_i;
      pc_o    <= ibus_addr_o;
    end
  end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import rv_core_pkg::*, rv_isa_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      clear_i,
  input  wire logic      valid_i,
  input  wire word_t     instr_i,
  input  wire pc_t       pc_i,
  output logic           ready_o,
  output reg_addr_t      rs1_o,
  output reg_addr_t      rs2_o,
  input  wire word_t     rs1_data_i,
  input  wire word_t     rs2_data_i,
  input  wire logic      wb_valid_i,
  input  wire logic      wb_we_i,
  input  wire reg_addr_t wb_rd_i,
  output logic           valid_o,
  output alu_cmd_t       alu_cmd_o,
  output word_t          alu_lhs_o,
  output word_t          alu_rhs_o,
  output br_cmd_t        br_cmd_o,
  output word_t          br_lhs_o,
  output word_t          br_rhs_o,
  output logic           branch_o,
  output logic           link_o,
  output logic           we_o,
  output reg_addr_t      rd_o,
  output pc_t            pc_o
);

  opcode_t opcode;
  funct3_t funct3;
  reg_addr_t rd;
  word_t i_imm;
  word_t u_imm;
  word_t b_imm;
  word_t j_imm;
  alu_cmd_t alu_cmd_d;
  word_t alu_lhs_d;
  word_t alu_rhs_d;
  br_cmd_t br_cmd_d;
  logic branch_d;
  logic link_d;
  logic we_d;
  logic use_rs1;
  logic use_rs2;
  logic rs1_hit;
  logic rs2_hit;

  always_comb begin
    opcode = opcode_t'(instr_i[6:0]);
    funct3 = instr_i[FUNCT3_LSB +: $bits(funct3_t)];
    rd     = instr_i[RD_LSB +: $bits(reg_addr_t)];
    rs1_o  = instr_i[RS1_LSB +: $bits(reg_addr_t)];
    rs2_o  = instr_i[RS2_LSB +: $bits(reg_addr_t)];
    i_imm  = {{20{instr_i[31]}}, instr_i[31:20]};
    u_imm  = {instr_i[31:12], 12'b0};
    b_imm  = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    j_imm  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  end

  always_comb begin
    alu_cmd_d = alu_cmd_t'(funct3);
    alu_lhs_d = rs1_data_i;
    alu_rhs_d = rs2_data_i;
    br_cmd_d  = BR_EQ;
    branch_d  = 1'b0;
    link_d    = 1'b0;
    we_d      = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_cmd_d = ALU_ADD;
        alu_lhs_d = u_imm;
        alu_rhs_d = '0;
        we_d      = 1'b1;
      end
      OP_IMM: begin
        alu_rhs_d = i_imm;
        we_d      = 1'b1;
        use_rs1   = 1'b1;
      end
      OP_REG: begin
        we_d    = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OP_JAL: begin
        // Target from the ALU, link value added in execute
        alu_cmd_d = ALU_ADD;
        alu_lhs_d = {pc_i, 2'b00};
        alu_rhs_d = j_imm;
        branch_d  = 1'b1;
        link_d    = 1'b1;
        we_d      = 1'b1;
      end
      OP_BRANCH: begin
        alu_cmd_d = ALU_ADD;
        alu_lhs_d = {pc_i, 2'b00};
        alu_rhs_d = b_imm;
        br_cmd_d  = br_cmd_t'(funct3);
        branch_d  = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      default: ;
    endcase
  end

  // RAW against the instruction in execute and the one being written back
  assign rs1_hit = use_rs1 && (rs1_o != '0) &&
                   ((valid_o && we_o && rs1_o == rd_o) ||
                    (wb_valid_i && wb_we_i && rs1_o == wb_rd_i));
  assign rs2_hit = use_rs2 && (rs2_o != '0) &&
                   ((valid_o && we_o && rs2_o == rd_o) ||
                    (wb_valid_i && wb_we_i && rs2_o == wb_rd_i));
  assign ready_o = !(rs1_hit || rs2_hit);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      valid_o <= 1'b0;
    end else begin
      // Stall cycles go out as bubbles
      valid_o <= valid_i && ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      alu_cmd_o <= alu_cmd_d;
      alu_lhs_o <= alu_lhs_d;
      alu_rhs_o <= alu_rhs_d;
      br_cmd_o  <= br_cmd_d;
      br_lhs_o  <= rs1_data_i;
      br_rhs_o  <= rs2_data_i;
      branch_o  <= branch_d;
      link_o    <= link_d;
      we_o      <= we_d;
      rd_o      <= rd;
      pc_o      <= pc_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import rv_core_pkg::*, rv_isa_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      valid_i,
  input  wire alu_cmd_t  alu_cmd_i,
  input  wire word_t     alu_lhs_i,
  input  wire word_t     alu_rhs_i,
  input  wire br_cmd_t   br_cmd_i,
  input  wire word_t     br_lhs_i,
  input  wire word_t     br_rhs_i,
  input  wire logic      branch_i,
  input  wire logic      link_i,
  input  wire logic      we_i,
  input  wire reg_addr_t rd_i,
  input  wire pc_t       pc_i,
  output logic           redir_valid_o,
  output pc_t            redir_pc_o,
  output logic           wb_valid_o,
  output logic           wb_we_o,
  output reg_addr_t      wb_rd_o,
  output word_t          wb_data_o
);

  function automatic word_t alu_op(alu_cmd_t cmd, word_t lhs, word_t rhs);
    case (cmd)
      ALU_ADD:  return lhs + rhs;
      ALU_SLL:  return lhs << rhs[4:0];
      ALU_SLT:  return word_t'($signed(lhs) < $signed(rhs));
      ALU_SLTU: return word_t'(lhs < rhs);
      ALU_XOR:  return lhs ^ rhs;
      ALU_SRL:  return lhs >> rhs[4:0];
      ALU_OR:   return lhs | rhs;
      ALU_AND:  return lhs & rhs;
      default:  return '0;
    endcase
  endfunction

  function automatic logic br_cond(br_cmd_t cmd, word_t lhs, word_t rhs);
    case (cmd)
      BR_EQ:   return lhs == rhs;
      BR_NE:   return lhs != rhs;
      BR_LT:   return $signed(lhs) < $signed(rhs);
      BR_GE:   return $signed(lhs) >= $signed(rhs);
      BR_LTU:  return lhs < rhs;
      BR_GEU:  return lhs >= rhs;
      default: return 1'b0;
    endcase
  endfunction

  word_t alu_res;
  word_t link_val;
  logic accept;
  logic taken;

  always_comb begin
    alu_res  = alu_op(alu_cmd_i, alu_lhs_i, alu_rhs_i);
    link_val = {pc_i, 2'b00} + word_t'(4);
    // Squash the instruction behind a taken branch while the redirect is out
    accept   = valid_i && !redir_valid_o;
    taken    = accept && (link_i || (branch_i && br_cond(br_cmd_i, br_lhs_i, br_rhs_i)));
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      redir_valid_o <= 1'b0;
      wb_valid_o    <= 1'b0;
    end else begin
      redir_valid_o <= taken;
      wb_valid_o    <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    redir_pc_o <= alu_res[XLEN-1:2];
    wb_we_o    <= we_i;
    wb_rd_o    <= rd_i;
    wb_data_o  <= branch_i ? link_val : alu_res;
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_core_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      valid_i,
  input  wire logic      we_i,
  input  wire reg_addr_t rd_i,
  input  wire word_t     data_i,
  input  wire reg_addr_t rs1_i,
  input  wire reg_addr_t rs2_i,
  output word_t          rs1_data_o,
  output word_t          rs2_data_o,
  output logic           wb_we_o,
  output reg_addr_t      wb_rd_o,
  output word_t          wb_data_o
);

  word_t regs [NUM_REGS];

  assign wb_we_o   = valid_i && we_i && (rd_i != '0);
  assign wb_rd_o   = rd_i;
  assign wb_data_o = data_i;

  // x0 is never stored and always reads as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk_i) begin
    if (wb_we_o) begin
      regs[rd_i] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_core_pkg::*, rv_isa_pkg::*; #(
  parameter pc_t BOOT_PC = '0
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  output logic       ibus_cyc_o,
  output logic       ibus_stb_o,
  output pc_t        ibus_addr_o,
  input  wire logic  ibus_stall_i,
  input  wire logic  ibus_ack_i,
  input  wire word_t ibus_data_i,
  output logic       wb_we_o,
  output reg_addr_t  wb_rd_o,
  output word_t      wb_data_o
);

  // Fetch to decode
  logic if_valid;
  word_t if_instr;
  pc_t if_pc;
  logic id_ready;

  // Register file read ports
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t rs1_data;
  word_t rs2_data;

  // Decode to execute
  logic id_valid;
  alu_cmd_t id_alu_cmd;
  word_t id_alu_lhs;
  word_t id_alu_rhs;
  br_cmd_t id_br_cmd;
  word_t id_br_lhs;
  word_t id_br_rhs;
  logic id_branch;
  logic id_link;
  logic id_we;
  reg_addr_t id_rd;
  pc_t id_pc;

  // Execute to write-back, and the redirect
  logic ex_valid;
  logic ex_we;
  reg_addr_t ex_rd;
  word_t ex_data;
  logic redir_valid;
  pc_t redir_pc;

  fetch_unit #(
    .BOOT_PC(BOOT_PC)
  ) i_fetch_unit (
    .clk_i,
    .rst_n_i,
    .redir_valid_i(redir_valid),
    .redir_pc_i   (redir_pc),
    .ready_i      (id_ready),
    .valid_o      (if_valid),
    .instr_o      (if_instr),
    .pc_o         (if_pc),
    .ibus_cyc_o,
    .ibus_stb_o,
    .ibus_addr_o,
    .ibus_stall_i,
    .ibus_ack_i,
    .ibus_data_i
  );

  decode_stage i_decode_stage (
    .clk_i,
    .rst_n_i,
    .clear_i   (redir_valid),
    .valid_i   (if_valid),
    .instr_i   (if_instr),
    .pc_i      (if_pc),
    .ready_o   (id_ready),
    .rs1_o     (rs1_addr),
    .rs2_o     (rs2_addr),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .wb_valid_i(ex_valid),
    .wb_we_i   (ex_we),
    .wb_rd_i   (ex_rd),
    .valid_o   (id_valid),
    .alu_cmd_o (id_alu_cmd),
    .alu_lhs_o (id_alu_lhs),
    .alu_rhs_o (id_alu_rhs),
    .br_cmd_o  (id_br_cmd),
    .br_lhs_o  (id_br_lhs),
    .br_rhs_o  (id_br_rhs),
    .branch_o  (id_branch),
    .link_o    (id_link),
    .we_o      (id_we),
    .rd_o      (id_rd),
    .pc_o      (id_pc)
  );

  execute_stage i_execute_stage (
    .clk_i,
    .rst_n_i,
    .valid_i      (id_valid),
    .alu_cmd_i    (id_alu_cmd),
    .alu_lhs_i    (id_alu_lhs),
    .alu_rhs_i    (id_alu_rhs),
    .br_cmd_i     (id_br_cmd),
    .br_lhs_i     (id_br_lhs),
    .br_rhs_i     (id_br_rhs),
    .branch_i     (id_branch),
    .link_i       (id_link),
    .we_i         (id_we),
    .rd_i         (id_rd),
    .pc_i         (id_pc),
    .redir_valid_o(redir_valid),
    .redir_pc_o   (redir_pc),
    .wb_valid_o   (ex_valid),
    .wb_we_o      (ex_we),
    .wb_rd_o      (ex_rd),
    .wb_data_o    (ex_data)
  );

  reg_file i_reg_file (
    .clk_i,
    .valid_i   (ex_valid),
    .we_i      (ex_we),
    .rd_i      (ex_rd),
    .data_i    (ex_data),
    .rs1_i     (rs1_addr),
    .rs2_i     (rs2_addr),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wb_we_o,
    .wb_rd_o,
    .wb_data_o
  );

endmodule

`default_nettype wire

//--- bench/rv_core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_asserts import rv_core_pkg::*; (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic ibus_cyc_i,
  input wire logic ibus_stb_i,
  input wire pc_t  ibus_addr_i,
  input wire logic ibus_stall_i
);

  stb_inside_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_stb_i |-> ibus_cyc_i)
    else $error("stb high while cyc is low");

  // A stalled request keeps its strobe and address
  stall_holds_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_stb_i && ibus_stall_i |=> ibus_stb_i && $stable(ibus_addr_i))
    else $error("stalled request was not held");

  bus_quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !ibus_cyc_i && !ibus_stb_i)
    else $error("cyc or stb high during reset");

endmodule

bind fetch_unit rv_core_asserts i_rv_core_asserts (
  .clk_i,
  .rst_n_i,
  .ibus_cyc_i  (ibus_cyc_o),
  .ibus_stb_i  (ibus_stb_o),
  .ibus_addr_i (ibus_addr_o),
  .ibus_stall_i
);

`default_nettype wire

//--- bench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core
  import rv_core_pkg::*, rv_isa_pkg::*;
();

  localparam pc_t BOOT_PC   = 30'd16;
  localparam int  MEM_WORDS = 256;
  localparam int  TIMEOUT   = 500;

  logic      clk;
  logic      rst_n;
  logic      ibus_cyc;
  logic      ibus_stb;
  pc_t       ibus_addr;
  logic      ibus_stall;
  logic      ibus_ack;
  word_t     ibus_data;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  word_t mem [MEM_WORDS];
  logic [31:0] lfsr;
  logic accepted;
  pc_t accepted_addr;

  word_t prog[$];
  reg_addr_t exp_rd[$];
  word_t exp_data[$];
  reg_addr_t got_rd[$];
  word_t got_data[$];
  pc_t fetch_addrs[$];

  string test_name;
  int test_fails;
  int fails;
  int checks;
  int tests;

  rv_core #(
    .BOOT_PC(BOOT_PC)
  ) i_rv_core (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .ibus_cyc_o  (ibus_cyc),
    .ibus_stb_o  (ibus_stb),
    .ibus_addr_o (ibus_addr),
    .ibus_stall_i(ibus_stall),
    .ibus_ack_i  (ibus_ack),
    .ibus_data_i (ibus_data),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic word_t imm_op(funct3_t f3, reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return {imm[11:0], rs1, f3, rd, OP_IMM};
  endfunction

  function automatic word_t reg_op(funct3_t f3, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {7'b0, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t lui_op(reg_addr_t rd, logic [19:0] upper);
    return {upper, rd, OP_LUI};
  endfunction

  function automatic word_t jal_op(reg_addr_t rd, word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t branch_op(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, word_t off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  // Request seen mid-cycle is accepted at the next edge and acked one cycle later
  always @(negedge clk) begin
    accepted = rst_n && ibus_stb && !ibus_stall;
    if (accepted) begin
      accepted_addr = ibus_addr;
      fetch_addrs.push_back(ibus_addr);
    end
  end

  always @(posedge clk) begin
    #1;
    ibus_ack   = accepted;
    ibus_data  = accepted ? mem[accepted_addr[7:0]] : '0;
    lfsr       = lfsr_next(lfsr);
    ibus_stall = lfsr[0];
  end

  task automatic note_failure();
    test_fails++;
    fails++;
  endtask

  // Write-back monitor
  always @(negedge clk) begin
    if (rst_n && wb_we) begin
      checks++;
      assert (wb_rd != '0) else begin
        note_failure();
        $display("%s: register x0 was written with %h", test_name, wb_data);
      end
      got_rd.push_back(wb_rd);
      got_data.push_back(wb_data);
    end
  end

  task automatic begin_test(string name);
    test_name  = name;
    test_fails = 0;
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
  endtask

  task automatic expect_write(reg_addr_t rd, word_t data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task automatic run_program(int writes);
    int cycles;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    // Opcode 0 everywhere else, so stray fetches retire without a write
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = word_t'(a) << 7;
    end
    foreach (prog[i]) begin
      mem[int'(BOOT_PC) + i] = prog[i];
    end
    repeat (16) @(posedge clk);
    #1;
    got_rd.delete();
    got_data.delete();
    fetch_addrs.delete();
    rst_n  = 1'b1;
    cycles = 0;
    while (got_rd.size() < writes && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    checks++;
    assert (got_rd.size() >= writes) else begin
      note_failure();
      $display("%s: timed out after %0d cycles with %0d of %0d writes",
               test_name, cycles, got_rd.size(), writes);
    end
  endtask

  task automatic check_writes();
    for (int i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
      checks++;
      assert (got_rd[i] == exp_rd[i] && got_data[i] == exp_data[i]) else begin
        note_failure();
        $display("mismatch %s write %0d: expected x%0d=%h, actual x%0d=%h",
                 test_name, i, exp_rd[i], exp_data[i], got_rd[i], got_data[i]);
      end
    end
  endtask

  task automatic end_test();
    tests++;
    if (test_fails == 0) begin
      $display("%s: pass", test_name);
    end else begin
      $display("%s: %0d failed checks", test_name, test_fails);
    end
  endtask

  task automatic fetch_order_test();
    begin_test("fetch_order");
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(imm_op(ALU_ADD, r, 0, r * 3));
      expect_write(r, r * 3);
    end
    prog.push_back(jal_op(0, 0));
    run_program(4);
    check_writes();
    for (int i = 0; i < 4 && i < fetch_addrs.size(); i++) begin
      checks++;
      assert (fetch_addrs[i] == BOOT_PC + i) else begin
        note_failure();
        $display("mismatch %s fetch %0d: expected %h, actual %h",
                 test_name, i, pc_t'(BOOT_PC + i), fetch_addrs[i]);
      end
    end
    end_test();
  endtask

  task automatic hazard_chain_test();
    begin_test("hazard_chain");
    prog.push_back(lui_op(1, 20'h12345));
    prog.push_back(imm_op(ALU_ADD, 1, 1, 32'h678));
    prog.push_back(imm_op(ALU_ADD, 2, 1, -1));
    prog.push_back(imm_op(ALU_ADD, 3, 2, 32'h7ff));
    prog.push_back(reg_op(ALU_ADD, 4, 3, 1));
    prog.push_back(jal_op(0, 0));
    expect_write(1, 32'h12345000);
    expect_write(1, 32'h12345000 + 32'h678);
    expect_write(2, 32'h12345678 - 1);
    expect_write(3, 32'h12345677 + 32'h7ff);
    expect_write(4, 32'h12345e76 + 32'h12345678);
    run_program(5);
    check_writes();
    end_test();
  endtask

  task automatic alu_ops_test();
    word_t a;
    word_t b;
    begin_test("alu_ops");
    a = 32'h87654321;
    b = 32'hfffffff3;
    prog.push_back(lui_op(1, 20'h87654));
    prog.push_back(imm_op(ALU_ADD, 1, 1, 32'h321));
    prog.push_back(imm_op(ALU_ADD, 2, 0, -13));
    prog.push_back(imm_op(ALU_ADD, 3, 1, -5));
    prog.push_back(imm_op(ALU_SLL, 4, 1, 4));
    prog.push_back(imm_op(ALU_SLT, 5, 1, 1));
    prog.push_back(imm_op(ALU_SLTU, 6, 1, 1));
    prog.push_back(imm_op(ALU_XOR, 7, 1, -1));
    prog.push_back(imm_op(ALU_SRL, 8, 1, 8));
    prog.push_back(imm_op(ALU_OR, 9, 1, 32'h0f0));
    prog.push_back(imm_op(ALU_AND, 10, 1, 32'h7f0));
    prog.push_back(reg_op(ALU_ADD, 11, 1, 2));
    prog.push_back(reg_op(ALU_SLL, 12, 1, 2));
    prog.push_back(reg_op(ALU_SLT, 13, 1, 2));
    prog.push_back(reg_op(ALU_SLTU, 14, 2, 1));
    prog.push_back(reg_op(ALU_XOR, 15, 1, 2));
    prog.push_back(reg_op(ALU_SRL, 16, 1, 2));
    prog.push_back(reg_op(ALU_OR, 17, 1, 2));
    prog.push_back(reg_op(ALU_AND, 18, 1, 2));
    prog.push_back(jal_op(0, 0));
    expect_write(1, 32'h87654000);
    expect_write(1, a);
    expect_write(2, b);
    expect_write(3, a - 5);
    expect_write(4, a << 4);
    // a is negative when signed, and below b when unsigned
    expect_write(5, 32'd1);
    expect_write(6, 32'd0);
    expect_write(7, ~a);
    expect_write(8, a >> 8);
    expect_write(9, a | 32'h0f0);
    expect_write(10, a & 32'h7f0);
    expect_write(11, a + b);
    // Shift amount is rs2[4:0], here 19
    expect_write(12, a << 19);
    expect_write(13, 32'd1);
    expect_write(14, 32'd0);
    expect_write(15, a ^ b);
    expect_write(16, a >> 19);
    expect_write(17, a | b);
    expect_write(18, a & b);
    run_program(19);
    check_writes();
    end_test();
  endtask

  task automatic jal_test();
    begin_test("jal");
    prog.push_back(imm_op(ALU_ADD, 1, 0, 7));
    // Jumps over two words to BOOT_PC + 4
    prog.push_back(jal_op(2, 12));
    prog.push_back(imm_op(ALU_ADD, 3, 0, 1));
    prog.push_back(imm_op(ALU_ADD, 3, 0, 2));
    prog.push_back(imm_op(ALU_ADD, 4, 1, 5));
    prog.push_back(jal_op(0, 0));
    expect_write(1, 7);
    expect_write(2, (word_t'(BOOT_PC) + 1) * 4 + 4);
    expect_write(4, 7 + 5);
    run_program(3);
    check_writes();
    end_test();
  endtask

  // Branch over a marker that writes its id to x10 only when not taken
  task automatic branch_case(br_cmd_t cmd, reg_addr_t rs1, reg_addr_t rs2, bit taken, int id);
    prog.push_back(branch_op(cmd, rs1, rs2, 8));
    prog.push_back(imm_op(ALU_ADD, 10, 0, id));
    if (!taken) begin
      expect_write(10, id);
    end
  endtask

  task automatic branch_test();
    begin_test("branches");
    prog.push_back(imm_op(ALU_ADD, 1, 0, -3));
    prog.push_back(imm_op(ALU_ADD, 2, 0, 5));
    expect_write(1, -3);
    expect_write(2, 5);
    // x1 = -3, x2 = 5
    branch_case(BR_EQ, 1, 1, 1'b1, 1);
    branch_case(BR_EQ, 1, 2, 1'b0, 2);
    branch_case(BR_NE, 1, 2, 1'b1, 3);
    branch_case(BR_NE, 1, 1, 1'b0, 4);
    branch_case(BR_LT, 1, 2, 1'b1, 5);
    branch_case(BR_LT, 2, 1, 1'b0, 6);
    branch_case(BR_GE, 2, 1, 1'b1, 7);
    branch_case(BR_GE, 1, 2, 1'b0, 8);
    branch_case(BR_LTU, 2, 1, 1'b1, 9);
    branch_case(BR_LTU, 1, 2, 1'b0, 10);
    branch_case(BR_GEU, 1, 2, 1'b1, 11);
    branch_case(BR_GEU, 2, 1, 1'b0, 12);
    prog.push_back(jal_op(0, 0));
    run_program(8);
    check_writes();
    end_test();
  endtask

  task automatic zero_reg_test();
    begin_test("zero_reg");
    prog.push_back(imm_op(ALU_ADD, 0, 0, 55));
    prog.push_back(lui_op(0, 20'habcde));
    prog.push_back(reg_op(ALU_ADD, 3, 0, 0));
    prog.push_back(imm_op(ALU_OR, 4, 0, 9));
    prog.push_back(jal_op(0, 0));
    expect_write(3, 0);
    expect_write(4, 9);
    run_program(2);
    check_writes();
    end_test();
  endtask

  initial begin
    rst_n         = 1'b0;
    ibus_stall    = 1'b0;
    ibus_ack      = 1'b0;
    ibus_data     = '0;
    accepted      = 1'b0;
    accepted_addr = '0;
    lfsr          = 32'hf7c22f07;
    fails         = 0;
    checks        = 0;
    tests         = 0;
    test_name     = "";
    fetch_order_test();
    hazard_chain_test();
    alu_ops_test();
    jal_test();
    branch_test();
    zero_reg_test();
    $display("%0d tests, %0d checks, %0d failed", tests, checks, fails);
    if (fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/rv_core.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv
